// File: coupe_macros.svh
// Shared constants for the Coupe ASIC core; include wherever port numbers or widths are needed
`ifndef COUPE_MACROS_SVH
`define COUPE_MACROS_SVH

// ======================================================================
// I/O port addresses, low byte of the port address only
// ======================================================================

// Paging and status
`define COUPE_PORT_LMPR 8'hFA
`define COUPE_PORT_HMPR 8'hFB
`define COUPE_PORT_STAT 8'hF9

// Border shares its number with the keyboard read port
`define COUPE_PORT_BRDR 8'hFE
`define COUPE_PORT_MIDI 8'hFD

// External RAM window registers
`define COUPE_PORT_EXTC 8'h80
`define COUPE_PORT_EXTD 8'h81

// Printer port, used as a two-byte DAC
`define COUPE_PORT_LPTD 8'hE8
`define COUPE_PORT_LPTS 8'hE9

// ======================================================================
// Timing and audio widths
// ======================================================================

// System clocks per 1 MHz tick
`define COUPE_TICK_DIV 96
`define COUPE_MIDI_BYTE_TICKS 319
`define COUPE_MIDI_INT_AT 15
`define COUPE_MIX_W 19
`define COUPE_SID_W 18

`endif

// File: coupe_pkg.sv
// Register and sample types shared by the Coupe ASIC blocks; import where a type is used
`include "coupe_macros.svh"

package coupe_pkg;

	// ======================================================================
	// Paging registers
	// ======================================================================

	// Low memory page register, controls sections A and B
	typedef struct packed {
		logic       wp;
		logic       rom1_en;
		logic       rom0_dis;
		logic [4:0] page_ab;
	} lmpr_t;

	// High memory page register, controls sections C and D
	typedef struct packed {
		logic       ext_ram;
		logic [1:0] mode3_hi;
		logic [4:0] page_cd;
	} hmpr_t;

	// Top bit selects the external RAM pages
	typedef logic [8:0] ram_page_t;

	typedef logic [7:0] port_byte_t;

	// ======================================================================
	// Audio
	// ======================================================================

	// Signed SID sample as produced by the SID engine
	typedef logic [`COUPE_SID_W-1:0] sid_sample_t;

	// Unsigned output sample
	typedef logic [15:0] audio_t;

endpackage

// File: asic_ports.sv
// Port decode and register file of the ASIC; instantiated once by the core top level
`timescale 1ns/10ps
`include "coupe_macros.svh"

module asic_ports import coupe_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       port_wr,
	input  logic [15:0] port_addr,
	input  port_byte_t port_wdata,
	input  logic       int_midi,
	input  logic       ext_ram_off,
	output port_byte_t port_rdata,
	output lmpr_t      lmpr,
	output hmpr_t      hmpr,
	output port_byte_t ext_c,
	output port_byte_t ext_d,
	output logic       ext_disable,
	output logic       beeper,
	output logic       midi_write,
	output logic       lptd_write,
	output logic       lpts_write
);

	// Only the low byte selects a port
	port_byte_t port_lo;
	logic       lmpr_sel;
	logic       hmpr_sel;
	logic       brdr_sel;
	logic       extc_sel;
	logic       extd_sel;

	assign port_lo  = port_addr[7:0];
	assign lmpr_sel = (port_lo == `COUPE_PORT_LMPR);
	assign hmpr_sel = (port_lo == `COUPE_PORT_HMPR);
	assign brdr_sel = (port_lo == `COUPE_PORT_BRDR);
	assign extc_sel = (port_lo == `COUPE_PORT_EXTC);
	assign extd_sel = (port_lo == `COUPE_PORT_EXTD);

	// Strobes for the blocks that keep their own state
	assign midi_write = port_wr & (port_lo == `COUPE_PORT_MIDI);
	assign lptd_write = port_wr & (port_lo == `COUPE_PORT_LPTD);
	assign lpts_write = port_wr & (port_lo == `COUPE_PORT_LPTS);

	// ======================================================================
	// Register writes
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lmpr   <= '0;
			hmpr   <= '0;
			ext_c  <= '0;
			ext_d  <= '0;
			beeper <= 1'b0;
			// Option pin sampled only while reset is held
			ext_disable <= ext_ram_off;
		end else if (port_wr) begin
			if (lmpr_sel)
				lmpr <= lmpr_t'(port_wdata);
			if (hmpr_sel)
				hmpr <= hmpr_t'(port_wdata);
			if (extc_sel)
				ext_c <= port_wdata;
			if (extd_sel)
				ext_d <= port_wdata;
			// Border bit 4 drives the beeper, the rest belongs to video
			if (brdr_sel)
				beeper <= port_wdata[4];
		end
	end

	// ======================================================================
	// Read-back mux
	// ======================================================================

	always_comb begin
		case (port_lo)
			`COUPE_PORT_LMPR: port_rdata = port_byte_t'(lmpr);
			`COUPE_PORT_HMPR: port_rdata = port_byte_t'(hmpr);
			// Interrupt flags are active low, only MIDI is modelled
			`COUPE_PORT_STAT: port_rdata = {3'b111, ~int_midi, 4'hF};
			default:          port_rdata = 8'hFF;
		endcase
	end

endmodule

// File: memory_map.sv
// Combinational CPU address translation; drives the RAM page and ROM select for each access
`timescale 1ns/10ps

module memory_map import coupe_pkg::*; (
	input  logic [15:0] mem_addr,
	input  lmpr_t       lmpr,
	input  hmpr_t       hmpr,
	input  port_byte_t  ext_c,
	input  port_byte_t  ext_d,
	input  logic        ext_disable,
	output ram_page_t   ram_page,
	output logic        rom_sel,
	output logic        ram_wp,
	output logic        ram_enable
);

	logic [1:0] quadrant;
	logic       ext_sel;
	logic [4:0] page_ab_next;
	logic [4:0] page_cd_next;

	assign quadrant = mem_addr[15:14];

	// External RAM replaces the upper 32K when enabled
	assign ext_sel = hmpr.ext_ram & mem_addr[15];

	// Odd sections use the next page, wrapping within 32 pages
	assign page_ab_next = lmpr.page_ab + 5'd1;
	assign page_cd_next = hmpr.page_cd + 5'd1;

	always_comb begin
		if (ext_sel) begin
			ram_page = {1'b1, (mem_addr[14] ? ext_d : ext_c)};
		end else begin
			case (quadrant)
				2'd0:    ram_page = {4'd0, lmpr.page_ab};
				2'd1:    ram_page = {4'd0, page_ab_next};
				2'd2:    ram_page = {4'd0, hmpr.page_cd};
				default: ram_page = {4'd0, page_cd_next};
			endcase
		end
	end

	// ROM0 sits in section A unless disabled, ROM1 in section D when enabled
	assign rom_sel = ((quadrant == 2'd0) & ~lmpr.rom0_dis) |
		((quadrant == 2'd3) & lmpr.rom1_en);

	assign ram_wp = lmpr.wp & (quadrant == 2'd0);

	// Missing external RAM
	assign ram_enable = ~(ext_sel & ext_disable);

endmodule

// File: midi_timer.sv
// MIDI transmit timing; makes the 1 MHz tick and raises the MIDI interrupt near the end of a byte
`timescale 1ns/10ps
`include "coupe_macros.svh"

module midi_timer (
	input  logic clk_sys,
	input  logic reset,
	input  logic midi_write,
	output logic tick_1m,
	output logic midi_busy,
	output logic int_midi
);

	logic [6:0] div_cnt;
	logic [8:0] tx_cnt;
	logic       pending;

	// ======================================================================
	// 1 MHz timebase
	// ======================================================================

	assign tick_1m = (div_cnt == 7'(`COUPE_TICK_DIV - 1));

	always_ff @(posedge clk_sys) begin
		if (reset)
			div_cnt <= '0;
		else if (tick_1m)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 7'd1;
	end

	// ======================================================================
	// Transmit countdown
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tx_cnt    <= '0;
			pending   <= 1'b0;
			midi_busy <= 1'b0;
			int_midi  <= 1'b0;
		end else begin
			if (tick_1m) begin
				if (tx_cnt != 9'd0) begin
					tx_cnt <= tx_cnt - 9'd1;
					if (tx_cnt == 9'(`COUPE_MIDI_INT_AT))
						int_midi <= 1'b1;
				end else begin
					midi_busy <= 1'b0;
					int_midi  <= 1'b0;
					// Start the next byte straight away
					if (pending) begin
						midi_busy <= 1'b1;
						tx_cnt    <= 9'(`COUPE_MIDI_BYTE_TICKS);
						pending   <= 1'b0;
					end
				end
			end

			// A write on the start tick is kept for the following byte
			if (midi_write)
				pending <= 1'b1;
		end
	end

endmodule

// File: sid_muter.sv
// Soft mute for the SID sample; fades it in and out on the 1 MHz tick, used inside the mixer
`timescale 1ns/10ps
`include "coupe_macros.svh"

module sid_muter import coupe_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        tick_1m,
	input  logic        enable,
	input  sid_sample_t vol_in,
	output sid_sample_t vol_out
);

	sid_sample_t vol_offset;
	sid_sample_t att;

	// Signed to offset binary
	assign vol_offset = {~vol_in[`COUPE_SID_W-1], vol_in[`COUPE_SID_W-2:0]};

	// Floor at zero rather than wrap
	assign vol_out = (vol_offset > att) ? (vol_offset - att) : '0;

	// Attenuation ramps one step per tick, saturating at both ends
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			att <= '1;
		end else if (tick_1m) begin
			if (enable && (att != '0))
				att <= att - 1'b1;
			else if (!enable && (att != '1))
				att <= att + 1'b1;
		end
	end

endmodule

// File: audio_mixer.sv
// Sound mixer with the printer-port DAC; sums all sources into the left and right outputs
`timescale 1ns/10ps
`include "coupe_macros.svh"

module audio_mixer import coupe_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        tick_1m,
	input  port_byte_t  port_wdata,
	input  logic        lptd_write,
	input  logic        lpts_write,
	input  logic        beeper,
	input  port_byte_t  psg_l,
	input  port_byte_t  psg_r,
	input  sid_sample_t sid_sample,
	input  logic        sid_active,
	output audio_t      audio_l,
	output audio_t      audio_r
);

	port_byte_t  lpt_data;
	port_byte_t  vox_l;
	port_byte_t  vox_r;
	logic        old_stb;
	sid_sample_t sid_muted;

	logic [`COUPE_MIX_W-1:0] mix_l;
	logic [`COUPE_MIX_W-1:0] mix_r;

	// ======================================================================
	// Printer-port DAC
	// ======================================================================

	// Strobe edges steer the data byte to one channel or the other
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lpt_data <= '0;
			vox_l    <= '0;
			vox_r    <= '0;
			old_stb  <= 1'b0;
		end else begin
			if (lptd_write)
				lpt_data <= port_wdata;
			if (lpts_write) begin
				if (~old_stb & port_wdata[0])
					vox_l <= lpt_data;
				if (old_stb & ~port_wdata[0])
					vox_r <= lpt_data;
				old_stb <= port_wdata[0];
			end
		end
	end

	sid_muter sid_muter_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.tick_1m (tick_1m),
		.enable  (sid_active),
		.vol_in  (sid_sample),
		.vol_out (sid_muted)
	);

	// ======================================================================
	// Mixing
	// ======================================================================

	// Byte sources are stretched to 16 bits, beeper weighs 2^17
	assign mix_l = {1'b0, psg_l, psg_l, 2'b00} + {1'b0, beeper, 17'd0} +
		{1'b0, vox_l, vox_l, 2'b00} + {1'b0, sid_muted};
	assign mix_r = {1'b0, psg_r, psg_r, 2'b00} + {1'b0, beeper, 17'd0} +
		{1'b0, vox_r, vox_r, 2'b00} + {1'b0, sid_muted};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= mix_l[`COUPE_MIX_W-1 -: 16];
			audio_r <= mix_r[`COUPE_MIX_W-1 -: 16];
		end
	end

endmodule

// File: coupe_core.sv
// Top level of the Coupe ASIC core; connects ports, memory map, MIDI timer and audio mixer
`timescale 1ns/10ps

module coupe_core import coupe_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        port_wr,
	input  logic [15:0] port_addr,
	input  port_byte_t  port_wdata,
	output port_byte_t  port_rdata,
	input  logic        ext_ram_off,
	input  logic [15:0] mem_addr,
	output ram_page_t   ram_page,
	output logic        rom_sel,
	output logic        ram_wp,
	output logic        ram_enable,
	input  port_byte_t  psg_l,
	input  port_byte_t  psg_r,
	input  sid_sample_t sid_sample,
	input  logic        sid_active,
	output audio_t      audio_l,
	output audio_t      audio_r,
	output logic        midi_busy,
	output logic        int_midi
);

	lmpr_t      lmpr;
	hmpr_t      hmpr;
	port_byte_t ext_c;
	port_byte_t ext_d;
	logic       ext_disable;
	logic       beeper;
	logic       midi_write;
	logic       lptd_write;
	logic       lpts_write;
	logic       tick_1m;

	asic_ports asic_ports_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.port_wr     (port_wr),
		.port_addr   (port_addr),
		.port_wdata  (port_wdata),
		.int_midi    (int_midi),
		.ext_ram_off (ext_ram_off),
		.port_rdata  (port_rdata),
		.lmpr        (lmpr),
		.hmpr        (hmpr),
		.ext_c       (ext_c),
		.ext_d       (ext_d),
		.ext_disable (ext_disable),
		.beeper      (beeper),
		.midi_write  (midi_write),
		.lptd_write  (lptd_write),
		.lpts_write  (lpts_write)
	);

	memory_map memory_map_i (
		.mem_addr    (mem_addr),
		.lmpr        (lmpr),
		.hmpr        (hmpr),
		.ext_c       (ext_c),
		.ext_d       (ext_d),
		.ext_disable (ext_disable),
		.ram_page    (ram_page),
		.rom_sel     (rom_sel),
		.ram_wp      (ram_wp),
		.ram_enable  (ram_enable)
	);

	midi_timer midi_timer_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.midi_write (midi_write),
		.tick_1m    (tick_1m),
		.midi_busy  (midi_busy),
		.int_midi   (int_midi)
	);

	audio_mixer audio_mixer_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.tick_1m    (tick_1m),
		.port_wdata (port_wdata),
		.lptd_write (lptd_write),
		.lpts_write (lpts_write),
		.beeper     (beeper),
		.psg_l      (psg_l),
		.psg_r      (psg_r),
		.sid_sample (sid_sample),
		.sid_active (sid_active),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

endmodule

// File: coupe_checker.sv
// Protocol assertions for the Coupe core; bound to the core top level from the testbench
`timescale 1ns/10ps

module coupe_checker (
	input logic        clk_sys,
	input logic        reset,
	input logic        int_midi,
	input logic        midi_busy,
	input logic        ram_wp,
	input logic [15:0] mem_addr
);

	int fail_count = 0;

	// ======================================================================
	// MIDI flags
	// ======================================================================

	// Interrupt only ever rises inside a byte time
	int_needs_busy: assert property (@(posedge clk_sys) disable iff (reset)
		int_midi |-> midi_busy)
		else begin
			$error("int_midi high while midi_busy is low");
			fail_count++;
		end

	// Both flags come out of reset low
	flags_after_reset: assert property (@(posedge clk_sys)
		reset |=> (!int_midi && !midi_busy))
		else begin
			$error("MIDI flags not low in the cycle after reset");
			fail_count++;
		end

	// ======================================================================
	// Memory map
	// ======================================================================

	// Write protect covers section A only
	wp_in_section_a: assert property (@(posedge clk_sys) disable iff (reset)
		ram_wp |-> (mem_addr[15:14] == 2'b00))
		else begin
			$error("ram_wp high outside the lowest 16K");
			fail_count++;
		end

endmodule

// File: coupe_clock_gen.sv
// Testbench clock and reset source for the Coupe core; instantiated by the testbench top
`timescale 1ns/10ps

module coupe_clock_gen (
	output logic clk_sys,
	output logic reset
);

	// 40 ns period
	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Held for two rising edges, released just after the second
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1 reset = 1'b0;
	end

endmodule

// File: coupe_tb.sv
// Self-checking testbench for the Coupe core; runs the stimulus table, then the MIDI sequence
`timescale 1ns/10ps
`include "coupe_macros.svh"

module coupe_tb import coupe_pkg::*; ();

	typedef struct {
		string       name;
		logic        wr;
		logic [7:0]  port;
		logic [7:0]  data;
		logic [7:0]  rd_port;
		logic [15:0] maddr;
		logic [7:0]  exp_rd;
		logic [8:0]  exp_page;
		logic        exp_rom;
		logic        exp_wp;
		logic        exp_en;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
	} entry_t;

	logic clk_sys, reset, port_wr, ext_ram_off, sid_active, table_ready;
	logic [15:0] port_addr, mem_addr;
	port_byte_t port_wdata, port_rdata, psg_l, psg_r;
	sid_sample_t sid_sample;
	ram_page_t ram_page;
	logic rom_sel, ram_wp, ram_enable, midi_busy, int_midi;
	audio_t audio_l, audio_r;

	entry_t tests[$];
	integer seed;
	int errors, checks, cycles;
	// Expected register state, updated as entries are added
	logic [7:0] lr, hr, ec, ed, lpt, vl, vr;
	logic beep, stb;

	coupe_clock_gen clock_gen_i (.clk_sys(clk_sys), .reset(reset));

	coupe_core coupe_core_i (.*);

	bind coupe_core coupe_checker coupe_checker_i (
		.clk_sys(clk_sys), .reset(reset), .int_midi(int_midi),
		.midi_busy(midi_busy), .ram_wp(ram_wp), .mem_addr(mem_addr));

	// ======================================================================
	// Table construction
	// ======================================================================

	task automatic add(input string name, input logic wr, input logic [7:0] port,
			input logic [7:0] data, input logic [7:0] rd_port, input logic [15:0] a);
		entry_t e;
		logic [4:0] p5;
		logic [18:0] sl, sr;
		if (wr) begin
			case (port)
				`COUPE_PORT_LMPR: lr = data;
				`COUPE_PORT_HMPR: hr = data;
				`COUPE_PORT_EXTC: ec = data;
				`COUPE_PORT_EXTD: ed = data;
				`COUPE_PORT_BRDR: beep = data[4];
				`COUPE_PORT_LPTD: lpt = data;
				`COUPE_PORT_LPTS: begin
					if (!stb && data[0]) vl = lpt;
					if (stb && !data[0]) vr = lpt;
					stb = data[0];
				end
				default: ;
			endcase
		end
		case (a[15:14])
			2'd0: p5 = lr[4:0];
			2'd1: p5 = lr[4:0] + 5'd1;
			2'd2: p5 = hr[4:0];
			default: p5 = hr[4:0] + 5'd1;
		endcase
		e = '{name: name, wr: wr, port: port, data: data, rd_port: rd_port, maddr: a,
			default: '0};
		e.exp_rd = (rd_port == `COUPE_PORT_LMPR) ? lr :
			(rd_port == `COUPE_PORT_HMPR) ? hr : 8'hFF;
		e.exp_page = (hr[7] && a[15]) ? {1'b1, (a[14] ? ed : ec)} : {4'd0, p5};
		e.exp_rom = ((a[15:14] == 2'd0) && !lr[5]) || ((a[15:14] == 2'd3) && lr[6]);
		e.exp_wp = lr[7] && (a[15:14] == 2'd0);
		// ext_ram_off is held high through reset
		e.exp_en = !(hr[7] && a[15]);
		// Byte doubled and shifted by 2 is the byte times 1028
		sl = 19'd1028 * 19'(psg_l) + (19'(beep) << 17) + 19'd1028 * 19'(vl);
		sr = 19'd1028 * 19'(psg_r) + (19'(beep) << 17) + 19'd1028 * 19'(vr);
		e.exp_l = sl[18:3];
		e.exp_r = sr[18:3];
		tests.push_back(e);
	endtask

	// ======================================================================
	// Checking
	// ======================================================================

	task automatic check_val(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic apply(input entry_t e);
		@(posedge clk_sys);
		#1;
		port_wr = e.wr;
		port_addr = {8'hA5, e.port};
		port_wdata = e.data;
		mem_addr = e.maddr;
		@(posedge clk_sys);
		#1;
		port_wr = 1'b0;
		port_addr = {8'h00, e.rd_port};
		// Two edges after the write, so the mixer output has settled too
		@(posedge clk_sys);
		#10;
		check_val("port_rdata", port_rdata, e.exp_rd);
		check_val("ram_page", ram_page, e.exp_page);
		check_val("rom_sel", rom_sel, e.exp_rom);
		check_val("ram_wp", ram_wp, e.exp_wp);
		check_val("ram_enable", ram_enable, e.exp_en);
		check_val("audio_l", audio_l, e.exp_l);
		check_val("audio_r", audio_r, e.exp_r);
	endtask

	// Wait for a flag level, sampling mid-cycle
	task automatic wait_flag(input string what, input logic want, input int limit);
		cycles = 0;
		while ((want ? !midi_busy && what == "busy" || !int_midi && what == "int" :
				midi_busy || int_midi) && cycles < limit) begin
			@(posedge clk_sys);
			#10;
			cycles++;
		end
		checks++;
		assert (cycles < limit) else begin
			$display("MIDI %s did not reach %0b within %0d cycles", what, want, limit);
			errors++;
		end
	endtask

	task automatic run_midi();
		@(posedge clk_sys);
		#1;
		port_wr = 1'b1;
		port_addr = {8'h00, `COUPE_PORT_MIDI};
		port_wdata = 8'h90;
		@(posedge clk_sys);
		#1;
		port_wr = 1'b0;
		port_addr = {8'h00, `COUPE_PORT_STAT};
		wait_flag("busy", 1'b1, 97);
		wait_flag("int", 1'b1, 321 * `COUPE_TICK_DIV);
		check_val("port_rdata", port_rdata, 8'hEF);
		wait_flag("clear", 1'b0, 321 * `COUPE_TICK_DIV);
		check_val("port_rdata", port_rdata, 8'hFF);
	endtask

	// ======================================================================
	// Main sequence and watchdog
	// ======================================================================

	initial begin
		int err0;
		port_wr = 1'b0;
		port_addr = '0;
		port_wdata = '0;
		mem_addr = '0;
		ext_ram_off = 1'b1;
		psg_l = 8'h5A;
		psg_r = 8'h33;
		sid_active = 1'b0;
		table_ready = 1'b0;
		errors = 0;
		checks = 0;
		seed = 32'hc58d_4fb4;
		sid_sample = 18'($random(seed));
		{lr, hr, ec, ed, lpt, vl, vr, beep, stb} = '0;
		add("reset lmpr", 0, 8'h00, 8'h00, `COUPE_PORT_LMPR, 16'h0000);
		add("reset hmpr", 0, 8'h00, 8'h00, `COUPE_PORT_HMPR, 16'h4000);
		add("reset status", 0, 8'h00, 8'h00, `COUPE_PORT_STAT, 16'hC000);
		add("page a", 1, `COUPE_PORT_LMPR, 8'($random(seed)), `COUPE_PORT_LMPR, 16'h1234);
		add("page b", 1, `COUPE_PORT_HMPR, 8'($random(seed)) & 8'h7F, `COUPE_PORT_HMPR,
			16'h5678);
		add("page c", 0, 8'h00, 8'h00, `COUPE_PORT_BRDR, 16'h9ABC);
		add("page d", 0, 8'h00, 8'h00, 8'h00, 16'hDEF0);
		add("wrap b", 1, `COUPE_PORT_LMPR, 8'hDF, `COUPE_PORT_LMPR, 16'h4000);
		add("wrap d", 1, `COUPE_PORT_HMPR, 8'h1F, `COUPE_PORT_HMPR, 16'hC000);
		add("protect a", 0, 8'h00, 8'h00, `COUPE_PORT_LMPR, 16'h0100);
		add("ext c reg", 1, `COUPE_PORT_EXTC, 8'($random(seed)), `COUPE_PORT_STAT, 16'h2000);
		add("ext d reg", 1, `COUPE_PORT_EXTD, 8'($random(seed)), `COUPE_PORT_STAT, 16'h6000);
		add("ext win c", 1, `COUPE_PORT_HMPR, 8'($random(seed)) | 8'h80, `COUPE_PORT_HMPR,
			16'h8000);
		add("ext win d", 0, 8'h00, 8'h00, `COUPE_PORT_HMPR, 16'hC000);
		add("ext low", 0, 8'h00, 8'h00, `COUPE_PORT_LMPR, 16'h4000);
		add("beeper", 1, `COUPE_PORT_BRDR, 8'h10, `COUPE_PORT_BRDR, 16'h0000);
		add("vox data l", 1, `COUPE_PORT_LPTD, 8'($random(seed)) & 8'h7F, 8'h00, 16'h0000);
		add("vox strobe l", 1, `COUPE_PORT_LPTS, 8'h01, 8'h00, 16'h0000);
		add("vox data r", 1, `COUPE_PORT_LPTD, 8'($random(seed)) & 8'h7F, 8'h00, 16'h0000);
		add("vox strobe r", 1, `COUPE_PORT_LPTS, 8'h00, 8'h00, 16'h0000);
		table_ready = 1'b1;
		wait (!reset);
		foreach (tests[i]) begin
			err0 = errors;
			apply(tests[i]);
			$display("test %0d %s: %s", i, tests[i].name, (errors == err0) ? "ok" : "FAIL");
		end
		err0 = errors;
		run_midi();
		$display("test %0d midi: %s", tests.size(), (errors == err0) ? "ok" : "FAIL");
		// Concurrent assertion failures from the bound checker
		errors += coupe_core_i.coupe_checker_i.fail_count;
		$display("tests %0d, checks %0d, errors %0d", tests.size() + 1, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial begin
		wait (table_ready);
		repeat (tests.size() * 400 + 40000) @(posedge clk_sys);
		$display("Timeout: the run did not finish in the allowed number of cycles");
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: compile.f
+incdir+.
coupe_pkg.sv
asic_ports.sv
memory_map.sv
midi_timer.sv
sid_muter.sv
audio_mixer.sv
coupe_core.sv
coupe_checker.sv
coupe_clock_gen.sv
coupe_tb.sv
